/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_split_cache
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -j $(JOBS)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR JOBS VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

/* dv/split_cache_checker.sv */
`timescale 1ns/1ps

module split_cache_checker (
    input logic           clk,
    input logic           rst_n_i,
    input logic           stall_i,
    input split_pkg::op_t op_i,
    input logic           busy_i,
    input logic           alloc_i,
    input logic           split_i,
    input logic           resp_valid_i
);

    a_no_resp_in_sweep: assert property (@(posedge clk) disable iff (!rst_n_i)
        busy_i |-> !resp_valid_i)
        else $error("resp_valid_o high while busy_o is high");

    // two stages between acceptance and response
    a_load_latency: assert property (@(posedge clk) disable iff (!rst_n_i)
        (alloc_i && op_i == split_pkg::LD) |-> ##2 resp_valid_i)
        else $error("accepted load without response two cycles later");

    a_alloc_blocked: assert property (@(posedge clk) disable iff (!rst_n_i)
        alloc_i |-> (!stall_i && !busy_i))
        else $error("alloc_o high while stalled or busy");

    a_split_alloc: assert property (@(posedge clk) disable iff (!rst_n_i)
        split_i |-> alloc_i)
        else $error("split_o high without alloc_o");

endmodule

bind split_cache_top split_cache_checker u_checker (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .stall_i      (stall_i),
    .op_i         (op_i),
    .busy_i       (busy_o),
    .alloc_i      (alloc_o),
    .split_i      (split_o),
    .resp_valid_i (resp_valid_o)
);

/* dv/tb_split_cache.sv */
`timescale 1ns/1ps

module tb_split_cache;

    localparam int CL_SIZE  = 128;
    localparam int IDX_CNT  = 64;
    localparam int TAG_SIZE = 10;
    localparam int LINES    = IDX_CNT / 2;

    logic                           clk;
    logic                           rst_n_i;
    logic                           req_valid_i;
    logic                           stall_i;
    logic [split_pkg::ADDR_W-1:0]   addr_i;
    logic [CL_SIZE-1:0]             data_i;
    logic [split_pkg::SIZE_W-1:0]   size_i;
    split_pkg::op_t                 op_i;
    logic [TAG_SIZE-1:0]            tag_i;
    logic                           busy_o;
    logic                           alloc_o;
    logic                           split_o;
    logic                           resp_valid_o;
    logic [split_pkg::RESULT_W-1:0] resp_data_o;
    logic [TAG_SIZE-1:0]            resp_tag_o;

    logic [7:0]          ref_mem [2*LINES*16];  // bank, index, offset
    logic [31:0]         rng;
    int                  cyc;
    logic [TAG_SIZE-1:0] tag_cnt;
    logic                exp_busy;
    logic                exp_alloc;
    logic                exp_split;
    int                  exp_due[$];
    logic [31:0]         exp_data[$];
    logic [TAG_SIZE-1:0] exp_tag[$];

    split_cache_top #(.CL_SIZE(CL_SIZE), .IDX_CNT(IDX_CNT), .TAG_SIZE(TAG_SIZE)) u_dut (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .req_valid_i  (req_valid_i),
        .stall_i      (stall_i),
        .addr_i       (addr_i),
        .data_i       (data_i),
        .size_i       (size_i),
        .op_i         (op_i),
        .tag_i        (tag_i),
        .busy_o       (busy_o),
        .alloc_o      (alloc_o),
        .split_o      (split_o),
        .resp_valid_o (resp_valid_o),
        .resp_data_o  (resp_data_o),
        .resp_tag_o   (resp_tag_o)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    function automatic logic [31:0] next_rand();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    function automatic logic [CL_SIZE-1:0] random_line();
        logic [CL_SIZE-1:0] d;
        for (int w = 0; w < CL_SIZE / 32; w++) begin
            d[w*32 +: 32] = next_rand();
        end
        return d;
    endfunction

    // index wraps at bank depth, so distant lines alias
    function automatic int byte_slot(input logic [31:0] a);
        int idx;
        idx = int'((a >> 5) % LINES);
        return ((int'(a[4]) * LINES + idx) * 16) + int'(a[3:0]);
    endfunction

    function automatic logic [31:0] expected_load(input logic [31:0] a, input logic [1:0] size);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i <= int'(size); i++) begin
            r[i*8 +: 8] = ref_mem[byte_slot(a + 32'(i))];
        end
        return r;
    endfunction

    task automatic apply_store(input logic [31:0] a, input logic [CL_SIZE-1:0] d,
                               input logic [1:0] size);
        for (int i = 0; i <= int'(size); i++) begin
            ref_mem[byte_slot(a + 32'(i))] = d[i*8 +: 8];
        end
    endtask

    task automatic check_eq(input string what, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("Fail at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            $display("TB FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    // one request per call, then on to the next cycle
    task automatic drive(input logic valid, input logic stall, input logic [31:0] addr,
                         input logic [CL_SIZE-1:0] data, input logic [1:0] size,
                         input split_pkg::op_t op);
        logic       acc;
        logic [4:0] last_off;
        req_valid_i = valid;
        stall_i     = stall;
        addr_i      = addr;
        data_i      = data;
        size_i      = size;
        op_i        = op;
        tag_i       = tag_cnt;
        acc = valid && !stall && !exp_busy && (op == split_pkg::LD || op == split_pkg::ST);
        last_off  = 5'(addr[3:0]) + 5'(size);  // beyond 15 spills into the next line
        exp_alloc = acc;
        exp_split = acc && last_off > 5'd15;
        if (acc && op == split_pkg::ST) begin
            apply_store(addr, data, size);
        end
        if (acc && op == split_pkg::LD) begin
            exp_due.push_back(cyc + 2);
            exp_data.push_back(expected_load(addr, size));
            exp_tag.push_back(tag_cnt);
        end
        tag_cnt = tag_cnt + 1'b1;
        @(posedge clk);
        #1;
    endtask

    task automatic idle_cycle();
        drive(1'b0, 1'b0, 32'h0, '0, 2'd0, split_pkg::NOOP);
    endtask

    always @(negedge clk) begin
        if (rst_n_i) begin
            check_eq("busy_o", 32'(busy_o), 32'(exp_busy));
            check_eq("alloc_o", 32'(alloc_o), 32'(exp_alloc));
            check_eq("split_o", 32'(split_o), 32'(exp_split));
            if (exp_due.size() > 0 && exp_due[0] == cyc) begin
                check_eq("resp_valid_o", 32'(resp_valid_o), 32'd1);
                check_eq("resp_data_o", resp_data_o, exp_data[0]);
                check_eq("resp_tag_o", 32'(resp_tag_o), 32'(exp_tag[0]));
                exp_due.delete(0);
                exp_data.delete(0);
                exp_tag.delete(0);
            end else begin
                check_eq("resp_valid_o", 32'(resp_valid_o), 32'd0);
            end
        end
    end

    initial begin
        logic [31:0]    a;
        logic [31:0]    r;
        int             n;
        split_pkg::op_t op;
        clk         = 1'b0;
        rst_n_i     = 1'b0;
        req_valid_i = 1'b0;
        stall_i     = 1'b0;
        addr_i      = '0;
        data_i      = '0;
        size_i      = '0;
        op_i        = split_pkg::NOOP;
        tag_i       = '0;
        rng         = 32'h4d88;
        cyc         = 0;
        tag_cnt     = '0;
        exp_busy    = 1'b1;
        exp_alloc   = 1'b0;
        exp_split   = 1'b0;
        a           = '0;
        for (int i = 0; i < 2 * LINES * 16; i++) begin
            ref_mem[i] = 8'h00;
        end
        repeat (3) @(posedge clk);
        #1;
        rst_n_i = 1'b1;

        // stores during the sweep must be dropped
        n = 0;
        while (busy_o && n < 4 * LINES) begin
            a = next_rand();
            drive(1'b1, 1'b0, a, random_line(), 2'd3, split_pkg::ST);
            n++;
        end
        if (busy_o) begin
            $display("busy_o still high %0d cycles after reset release", n);
            $display("TB FAILED");
            $fatal(1, "sweep timeout");
        end
        check_eq("sweep cycles", 32'(n), 32'(LINES));
        exp_busy = 1'b0;
        drive(1'b1, 1'b0, a, '0, 2'd3, split_pkg::LD);  // last sweep store left no trace
        for (int i = 0; i < 8; i++) begin
            drive(1'b1, 1'b0, next_rand(), '0, 2'(i), split_pkg::LD);
        end

        for (int s = 0; s < 4; s++) begin
            a = next_rand() & 32'h0000_07fc;
            drive(1'b1, 1'b0, a, random_line(), 2'(s), split_pkg::ST);
            drive(1'b1, 1'b0, a, '0, 2'(s), split_pkg::LD);
        end

        // line crossings, even to odd and odd to even
        for (int par = 0; par < 2; par++) begin
            for (int off = 13; off < 16; off++) begin
                for (int s = 16 - off; s < 4; s++) begin
                    a = (next_rand() & 32'h0000_07e0) | 32'(par << 4) | 32'(off);
                    drive(1'b1, 1'b0, a, random_line(), 2'(s), split_pkg::ST);
                    drive(1'b1, 1'b0, a, '0, 2'(s), split_pkg::LD);
                    drive(1'b1, 1'b0, a, '0, 2'd0, split_pkg::LD);
                    drive(1'b1, 1'b0, (a & ~32'hf) + 32'h10, '0, 2'd0, split_pkg::LD);
                end
            end
        end

        a = 32'h0000_0148;
        drive(1'b1, 1'b0, a, random_line(), 2'd3, split_pkg::ST);
        drive(1'b1, 1'b1, a, random_line(), 2'd3, split_pkg::ST);  // stalled
        drive(1'b0, 1'b0, a, random_line(), 2'd3, split_pkg::ST);
        drive(1'b1, 1'b0, a, '0, 2'd3, split_pkg::LD);

        for (int i = 0; i < 300; i++) begin
            r = next_rand();
            case (r[9:8])
                2'd0, 2'd2: op = split_pkg::LD;
                2'd1:       op = split_pkg::ST;
                default:    op = r[12] ? split_pkg::NOOP : split_pkg::op_t'({1'b1, r[11:10]});
            endcase
            drive(r[3:0] != 4'd0, r[7:5] == 3'd0, next_rand() & 32'h0000_07ff,
                  random_line(), r[14:13], op);
        end

        n = 0;
        while (exp_due.size() > 0 && n < 10) begin
            idle_cycle();
            n++;
        end
        if (exp_due.size() != 0) begin
            $display("%0d load results never arrived", exp_due.size());
            $display("TB FAILED");
            $fatal(1, "response timeout");
        end else begin
            $display("TB PASSED");
            $finish;
        end
    end

endmodule

/* files.f */
rtl/split_pkg.sv
rtl/bank_req_if.sv
rtl/access_splitter.sv
rtl/line_bank.sv
rtl/load_merge.sv
rtl/init_ctrl.sv
rtl/init_counter.sv
rtl/split_cache_top.sv
dv/split_cache_checker.sv
dv/tb_split_cache.sv

/* rtl/access_splitter.sv */
`timescale 1ns/1ps

module access_splitter #(
    parameter int CL_SIZE  = 128,
    parameter int TAG_SIZE = 10
) (
    input  logic                             req_valid_i,
    input  logic                             stall_i,
    input  logic                             busy_i,
    input  logic [split_pkg::ADDR_W-1:0]     addr_i,
    input  logic [CL_SIZE-1:0]               data_i,
    input  logic [split_pkg::SIZE_W-1:0]     size_i,
    input  split_pkg::op_t                   op_i,
    input  logic [TAG_SIZE-1:0]              tag_i,
    bank_req_if.src                          even_o,
    bank_req_if.src                          odd_o,
    output logic                             alloc_o,
    output logic                             split_o,
    output logic                             first_even_o,
    output logic [split_pkg::CNT_W-1:0]      part0_bytes_o
);

    localparam int OFF_W = split_pkg::LINE_OFF_W;

    logic                         acc;
    logic [OFF_W:0]               ovf;   // offset + size, carry means line cross
    logic                         need_p1;
    logic [split_pkg::SIZE_W-1:0] size_0;
    logic [split_pkg::SIZE_W-1:0] size_1;
    logic [split_pkg::ADDR_W-1:0] addr_1;
    logic [CL_SIZE-1:0]           data_1;
    split_pkg::op_t               op_0;
    split_pkg::op_t               op_1;

    assign acc = req_valid_i && !stall_i && !busy_i &&
                 (op_i == split_pkg::LD || op_i == split_pkg::ST);

    assign ovf     = {1'b0, addr_i[OFF_W-1:0]} + (OFF_W + 1)'(size_i);
    assign need_p1 = ovf[OFF_W];

    // part 1 gets whatever spilled past the line end
    assign size_1 = ovf[split_pkg::SIZE_W-1:0];
    assign size_0 = need_p1 ? split_pkg::SIZE_W'(size_i - size_1 - 1'b1) : size_i;

    assign part0_bytes_o = split_pkg::CNT_W'(size_0) + split_pkg::CNT_W'(1);

    assign addr_1 = {addr_i[split_pkg::ADDR_W-1:OFF_W] + 1'b1, {OFF_W{1'b0}}};
    assign data_1 = data_i >> (part0_bytes_o * split_pkg::BYTE_W);

    assign op_0 = acc ? op_i : split_pkg::NOOP;
    assign op_1 = (acc && need_p1) ? op_i : split_pkg::NOOP;

    assign first_even_o = !addr_i[OFF_W];  // bank of part 0
    assign alloc_o      = acc;
    assign split_o      = acc && need_p1;

    // route by bank bit of the request address
    always_comb begin
        if (first_even_o) begin
            even_o.addr = addr_i;
            even_o.data = data_i;
            even_o.size = size_0;
            even_o.op   = op_0;
            odd_o.addr  = addr_1;
            odd_o.data  = data_1;
            odd_o.size  = size_1;
            odd_o.op    = op_1;
        end else begin
            odd_o.addr  = addr_i;
            odd_o.data  = data_i;
            odd_o.size  = size_0;
            odd_o.op    = op_0;
            even_o.addr = addr_1;
            even_o.data = data_1;
            even_o.size = size_1;
            even_o.op   = op_1;
        end
    end

    assign even_o.tag = tag_i;
    assign odd_o.tag  = tag_i;

endmodule

/* rtl/bank_req_if.sv */
`timescale 1ns/1ps

interface bank_req_if #(
    parameter int CL_SIZE  = 128,
    parameter int TAG_SIZE = 10
);

    logic [split_pkg::ADDR_W-1:0] addr;
    logic [CL_SIZE-1:0]           data;  // right aligned, low byte first
    logic [split_pkg::SIZE_W-1:0] size;
    split_pkg::op_t               op;    // NOOP = idle bank
    logic [TAG_SIZE-1:0]          tag;

    modport src (
        output addr, data, size, op, tag
    );

    modport bank (
        input addr, data, size, op, tag
    );

endinterface

/* rtl/init_counter.sv */
`timescale 1ns/1ps

module init_counter #(
    parameter int IDX_CNT = 64
) (
    input  logic                          clk,
    input  logic                          rst_n_i,
    input  logic                          en_i,
    output logic [$clog2(IDX_CNT/2)-1:0]  idx_o,
    output logic                          last_o
);

    localparam int LINES = IDX_CNT / 2;
    localparam int IDX_W = $clog2(LINES);

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            idx_o <= '0;
        end else if (en_i) begin
            idx_o <= last_o ? '0 : idx_o + 1'b1;
        end
    end

    assign last_o = (idx_o == IDX_W'(LINES - 1));

endmodule

/* rtl/init_ctrl.sv */
`timescale 1ns/1ps

module init_ctrl (
    input  logic clk,
    input  logic rst_n_i,
    input  logic last_i,
    output logic cnt_en_o,
    output logic busy_o
);

    typedef enum logic {
        SWEEP,
        RUN
    } state_t;

    state_t state_q;
    state_t state_d;

    always_comb begin
        state_d = state_q;
        case (state_q)
            SWEEP: begin
                if (last_i) begin
                    state_d = RUN;  // final index written this edge
                end
            end
            default: state_d = RUN;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state_q <= SWEEP;
        end else begin
            state_q <= state_d;
        end
    end

    assign cnt_en_o = (state_q == SWEEP);
    assign busy_o   = (state_q == SWEEP);

endmodule

/* rtl/line_bank.sv */
`timescale 1ns/1ps

module line_bank #(
    parameter int CL_SIZE  = 128,
    parameter int IDX_CNT  = 64,
    parameter int TAG_SIZE = 10
) (
    input  logic                              clk,
    input  logic                              rst_n_i,
    bank_req_if.bank                          req_i,
    input  logic                              clr_en_i,
    input  logic [$clog2(IDX_CNT/2)-1:0]      clr_idx_i,
    output logic [split_pkg::RESULT_W-1:0]    rd_data_o
);

    localparam int LINES = IDX_CNT / 2;
    localparam int IDX_W = $clog2(LINES);
    localparam int LANES = CL_SIZE / split_pkg::BYTE_W;
    localparam int OFF_W = split_pkg::LINE_OFF_W;

    if ($bits(req_i.tag) != TAG_SIZE || $bits(req_i.data) != CL_SIZE) begin : g_bad_width
        $error("line_bank: request interface width mismatch");
    end

    logic [CL_SIZE-1:0]               mem [LINES];
    logic [IDX_W-1:0]                 idx;
    logic [OFF_W-1:0]                 off;
    logic [split_pkg::MAX_BYTES-1:0]  size_mask;
    logic [LANES-1:0]                 lane_mask;
    logic [CL_SIZE-1:0]               wr_line;
    logic [CL_SIZE-1:0]               rd_line;
    logic [split_pkg::RESULT_W-1:0]   keep;

    // index aliases modulo bank depth
    assign idx = req_i.addr[OFF_W+1 +: IDX_W];
    assign off = req_i.addr[OFF_W-1:0];

    assign size_mask = {split_pkg::MAX_BYTES{1'b1}} >> (split_pkg::MAX_BYTES - 1 - req_i.size);
    assign lane_mask = LANES'(size_mask) << off;
    assign wr_line   = req_i.data << (off * split_pkg::BYTE_W);
    assign rd_line   = mem[idx] >> (off * split_pkg::BYTE_W);

    always_comb begin
        for (int b = 0; b < split_pkg::MAX_BYTES; b++) begin
            keep[b*split_pkg::BYTE_W +: split_pkg::BYTE_W] = {split_pkg::BYTE_W{size_mask[b]}};
        end
    end

    always_ff @(posedge clk) begin
        if (rst_n_i) begin
            if (clr_en_i) begin
                mem[clr_idx_i] <= '0;  // sweep owns the bank
            end else if (req_i.op == split_pkg::ST) begin
                for (int b = 0; b < LANES; b++) begin
                    if (lane_mask[b]) begin
                        mem[idx][b*split_pkg::BYTE_W +: split_pkg::BYTE_W] <=
                            wr_line[b*split_pkg::BYTE_W +: split_pkg::BYTE_W];
                    end
                end
            end
        end
    end

    // right aligned, zero filled above size
    always_ff @(posedge clk) begin
        if (!clr_en_i && req_i.op == split_pkg::LD) begin
            rd_data_o <= rd_line[split_pkg::RESULT_W-1:0] & keep;
        end
    end

endmodule

/* rtl/load_merge.sv */
`timescale 1ns/1ps

module load_merge #(
    parameter int TAG_SIZE = 10
) (
    input  logic                            clk,
    input  logic                            rst_n_i,
    input  logic                            ld_acc_i,
    input  logic                            split_i,
    input  logic                            first_even_i,
    input  logic [split_pkg::CNT_W-1:0]     part0_bytes_i,
    input  logic [TAG_SIZE-1:0]             tag_i,
    input  logic [split_pkg::RESULT_W-1:0]  even_data_i,
    input  logic [split_pkg::RESULT_W-1:0]  odd_data_i,
    output logic                            resp_valid_o,
    output logic [split_pkg::RESULT_W-1:0]  resp_data_o,
    output logic [TAG_SIZE-1:0]             resp_tag_o
);

    logic                           pend_q;  // load waiting on bank data
    logic                           split_q;
    logic                           first_even_q;
    logic [split_pkg::CNT_W-1:0]    p0_bytes_q;
    logic [TAG_SIZE-1:0]            tag_q;
    logic [split_pkg::RESULT_W-1:0] part0;
    logic [split_pkg::RESULT_W-1:0] part1;
    logic [split_pkg::RESULT_W-1:0] merged;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            pend_q       <= 1'b0;
            resp_valid_o <= 1'b0;
        end else begin
            pend_q       <= ld_acc_i;
            resp_valid_o <= pend_q;
        end
    end

    always_ff @(posedge clk) begin
        if (ld_acc_i) begin
            split_q      <= split_i;
            first_even_q <= first_even_i;
            p0_bytes_q   <= part0_bytes_i;
            tag_q        <= tag_i;
        end
    end

    assign part0  = first_even_q ? even_data_i : odd_data_i;
    assign part1  = first_even_q ? odd_data_i : even_data_i;
    assign merged = split_q ? (part0 | (part1 << (p0_bytes_q * split_pkg::BYTE_W))) : part0;

    always_ff @(posedge clk) begin
        resp_data_o <= merged;
        resp_tag_o  <= tag_q;
    end

endmodule

/* rtl/split_cache_top.sv */
`timescale 1ns/1ps

module split_cache_top #(
    parameter int CL_SIZE  = 128,
    parameter int IDX_CNT  = 64,
    parameter int TAG_SIZE = 10
) (
    input  logic                            clk,
    input  logic                            rst_n_i,
    input  logic                            req_valid_i,
    input  logic                            stall_i,
    input  logic [split_pkg::ADDR_W-1:0]    addr_i,
    input  logic [CL_SIZE-1:0]              data_i,
    input  logic [split_pkg::SIZE_W-1:0]    size_i,
    input  split_pkg::op_t                  op_i,
    input  logic [TAG_SIZE-1:0]             tag_i,
    output logic                            busy_o,
    output logic                            alloc_o,
    output logic                            split_o,
    output logic                            resp_valid_o,
    output logic [split_pkg::RESULT_W-1:0]  resp_data_o,
    output logic [TAG_SIZE-1:0]             resp_tag_o
);

    localparam int IDX_W = $clog2(IDX_CNT / 2);

    bank_req_if #(.CL_SIZE(CL_SIZE), .TAG_SIZE(TAG_SIZE)) even_bus ();
    bank_req_if #(.CL_SIZE(CL_SIZE), .TAG_SIZE(TAG_SIZE)) odd_bus ();

    logic                           first_even;
    logic [split_pkg::CNT_W-1:0]    part0_bytes;
    logic                           ld_acc;
    logic                           cnt_en;
    logic                           last;
    logic [IDX_W-1:0]               clr_idx;
    logic [split_pkg::RESULT_W-1:0] even_data;
    logic [split_pkg::RESULT_W-1:0] odd_data;

    // part 0 always carries the op of an accepted access
    assign ld_acc = alloc_o && (even_bus.op == split_pkg::LD || odd_bus.op == split_pkg::LD);

    access_splitter #(.CL_SIZE(CL_SIZE), .TAG_SIZE(TAG_SIZE)) u_splitter (
        .req_valid_i   (req_valid_i),
        .stall_i       (stall_i),
        .busy_i        (busy_o),
        .addr_i        (addr_i),
        .data_i        (data_i),
        .size_i        (size_i),
        .op_i          (op_i),
        .tag_i         (tag_i),
        .even_o        (even_bus),
        .odd_o         (odd_bus),
        .alloc_o       (alloc_o),
        .split_o       (split_o),
        .first_even_o  (first_even),
        .part0_bytes_o (part0_bytes)
    );

    line_bank #(.CL_SIZE(CL_SIZE), .IDX_CNT(IDX_CNT), .TAG_SIZE(TAG_SIZE)) u_even_bank (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .req_i     (even_bus),
        .clr_en_i  (cnt_en),
        .clr_idx_i (clr_idx),
        .rd_data_o (even_data)
    );

    line_bank #(.CL_SIZE(CL_SIZE), .IDX_CNT(IDX_CNT), .TAG_SIZE(TAG_SIZE)) u_odd_bank (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .req_i     (odd_bus),
        .clr_en_i  (cnt_en),
        .clr_idx_i (clr_idx),
        .rd_data_o (odd_data)
    );

    load_merge #(.TAG_SIZE(TAG_SIZE)) u_merge (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .ld_acc_i      (ld_acc),
        .split_i       (split_o),
        .first_even_i  (first_even),
        .part0_bytes_i (part0_bytes),
        .tag_i         (even_bus.tag),  // same tag on both parts
        .even_data_i   (even_data),
        .odd_data_i    (odd_data),
        .resp_valid_o  (resp_valid_o),
        .resp_data_o   (resp_data_o),
        .resp_tag_o    (resp_tag_o)
    );

    init_ctrl u_init_ctrl (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .last_i   (last),
        .cnt_en_o (cnt_en),
        .busy_o   (busy_o)
    );

    init_counter #(.IDX_CNT(IDX_CNT)) u_init_counter (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .en_i    (cnt_en),
        .idx_o   (clr_idx),
        .last_o  (last)
    );

endmodule

/* rtl/split_pkg.sv */
package split_pkg;

    // operation codes, anything besides LD and ST behaves as NOOP
    typedef enum logic [2:0] {
        NOOP = 3'd0,
        LD   = 3'd1,
        ST   = 3'd2
    } op_t;

    localparam int ADDR_W     = 32;
    localparam int SIZE_W     = 2;  // bytes minus one
    localparam int LINE_OFF_W = 4;  // byte offset inside a 16 byte line
    localparam int RESULT_W   = 32;

    localparam int BYTE_W    = 8;
    localparam int MAX_BYTES = RESULT_W / BYTE_W;  // widest single access
    // width of a part byte count, holds 1..MAX_BYTES
    localparam int CNT_W     = $clog2(MAX_BYTES + 1);

endpackage
